//--- filelist.f
+incdir+verilog
verilog/cpu_mem_pkg.sv
verilog/boot_host_seq.sv
verilog/data_mem.sv
verilog/instr_mem.sv
verilog/cpu_mem_top.sv
test/cpu_mem_asserts.sv
test/tb_cpu_mem.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_mem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f filelist.f --top-module tb_cpu_mem -o tb_cpu_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cpu_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- test/tb_cpu_mem.sv
`include "cpu_mem_defs.svh"

module tb_cpu_mem
    import cpu_mem_pkg::*;
();

    typedef enum logic [2:0] {OP_CRD, OP_CWR, OP_FRD, OP_HWR, OP_AWR, OP_AWC, OP_ARD} op_t;

    typedef struct packed {
        op_t                op;
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] data;
        logic [`ADDR_W-1:0] addr2;     // core store beside an accel write
        logic [`WORD_W-1:0] exp;
    } row_t;

    localparam int NROWS = 13;
    localparam logic [`ADDR_W-1:0] DM_BASES [`DM_SEGS] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140, 16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140, 16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };
    localparam row_t ROWS [NROWS] = '{
        '{OP_CRD, 16'h1000, 32'h0, 16'h0, 32'h0000_1000},
        '{OP_CRD, 16'h417c, 32'h0, 16'h0, 32'h0000_417c},
        '{OP_CRD, 16'h013c, 32'h0, 16'h0, 32'h0000_013c},
        '{OP_FRD, 16'h0000, 32'h0, 16'h0, 32'h0001_0000},
        '{OP_FRD, 16'h0bfc, 32'h0, 16'h0, 32'h0001_0bfc},
        '{OP_CWR, 16'h0500, 32'h1234_5678, 16'h0, 32'h0},
        '{OP_CRD, 16'h0500, 32'h0, 16'h0, 32'h1234_5678},
        '{OP_HWR, 16'h9044, 32'hdead_beef, 16'h0, 32'h0},
        '{OP_CRD, 16'h1044, 32'h0, 16'h0, 32'h0000_1044},   // trap left boot word alone
        '{OP_AWR, 16'h2104, 32'h0, 16'h0, 32'h0},
        '{OP_AWC, 16'h2108, 32'h0bad_cafe, 16'h0600, 32'h0},
        '{OP_CRD, 16'h0600, 32'h0, 16'h0, 32'h0bad_cafe},
        '{OP_ARD, 16'h2110, 32'h0, 16'h0, 32'h0000_2100}
    };

    logic                                clk;
    logic                                rst_n;
    logic                                ready, rd_valid, tx_done;
    logic [`WORD_W-1:0]                  host_rd_data;
    host_op_t                            host_op;
    logic [`HOST_ADDR_W-1:0]             host_addr;
    logic [`WORD_W-1:0]                  host_wr_data;
    core_req_t                           core_req;
    logic [`ADDR_W-1:0]                  fetch_addr;
    logic [`WORD_W-1:0]                  core_rdata, fetch_instr;
    logic                                stall;
    accel_req_t                          accel_req;
    logic                                accel_wr_done, accel_rd_valid;
    logic [`LINE_WORDS-1:0][`WORD_W-1:0] accel_line;

    int                 errors = 0;
    int                 timeouts = 0;
    logic [31:0]        lfsr = 32'hf209;
    logic [`WORD_W-1:0] accel_data [logic [`ADDR_W-1:0]];   // words written by the accelerator

    cpu_mem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string why);
        timeouts++;
        $display("ERROR at %0t: %s", $time, why);
    endtask

    ////////////////////////////////////////////////////////////
    // host side of the boot
    ////////////////////////////////////////////////////////////

    task automatic serve_boot();
        logic [`HOST_ADDR_W-1:0] seg_addr;
        int                      n;
        for (int s = 0; s < `DM_SEGS + `IM_SEGS; s++) begin
            if (s < `DM_SEGS) seg_addr = {48'h0, DM_BASES[s]};
            else seg_addr = 64'((s - `DM_SEGS) * 'h40) | (64'h1 << `IM_HOST_BIT);
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (host_op != READ && n < 50);
            if (host_op != READ) begin
                report_timeout($sformatf("no host READ for boot segment %0d", s));
                return;
            end
            check(host_addr, seg_addr, $sformatf("boot segment %0d address", s));
            check(stall, 1, "stall during boot");
            for (int w = 0; w < `SEG_WORDS; w++) begin
                @(posedge clk);
                rd_valid     <= (w == 0);
                tx_done      <= (w == `SEG_WORDS - 1);
                host_rd_data <= seg_addr[31:0] + 32'(4 * w);
            end
            @(posedge clk);
            rd_valid <= 1'b0;
            tx_done  <= 1'b0;
        end
        @(negedge clk);
        check(stall, 0, "stall after boot");
        check(host_op, IDLE, "host op after boot");
    endtask

    task automatic host_store(input logic [15:0] a, input logic [31:0] d);
        logic [31:0] delay;
        delay = 1 + rand_bits(3);   // cycles before tx_done
        @(posedge clk);
        core_req <= '{a, d, 1'b1, 1'b0};
        @(negedge clk);
        check(stall, 1, "stall in trap cycle");
        @(posedge clk);
        core_req <= '0;
        repeat (delay) begin
            @(negedge clk);
            check(host_op, WRITE, "host op during write");
            check(host_addr, {48'h0, a}, "host write address");
            check(host_wr_data, d, "host write data");
            check(stall, 1, "stall before tx_done");
        end
        @(posedge clk);
        tx_done <= 1'b1;
        @(negedge clk);
        check(host_op, WRITE, "host op with tx_done");
        check(stall, 0, "stall with tx_done");
        @(posedge clk);
        tx_done <= 1'b0;
        @(negedge clk);
        check(host_op, IDLE, "host op after write");
    endtask

    task automatic accel_write(input logic [15:0] a, input logic [31:0] d, input logic with_core,
                               input logic [15:0] ca, input logic [31:0] cd);
        int n;
        n = 0;
        accel_data[a] = d;
        @(posedge clk);
        accel_req <= '{a, d, 1'b1, 1'b0};
        if (with_core) begin
            core_req <= '{ca, cd, 1'b1, 1'b0};
            @(posedge clk);
            core_req <= '0;
            @(negedge clk);
            check(accel_wr_done, 0, "accel done while core store wins");
        end
        do begin
            @(negedge clk);
            n++;
        end while (!accel_wr_done && n < 20);
        if (!accel_wr_done) begin
            report_timeout("accel write never acknowledged");
        end
        @(posedge clk);
        accel_req <= '0;
    endtask

    task automatic apply_row(input row_t row);
        logic [`ADDR_W-1:0] base;
        logic [`ADDR_W-1:0] wa;
        case (row.op)
            OP_CRD: begin
                @(posedge clk);
                core_req <= '{row.addr, 32'h0, 1'b0, 1'b1};
                @(posedge clk);
                core_req <= '0;
                @(negedge clk);
                check(core_rdata, row.exp, $sformatf("core load at %h", row.addr));
            end
            OP_CWR: begin
                @(posedge clk);
                core_req <= '{row.addr, row.data, 1'b1, 1'b0};
                @(posedge clk);
                core_req <= '0;
            end
            OP_FRD: begin
                @(posedge clk);
                fetch_addr <= row.addr;
                @(posedge clk);
                @(negedge clk);
                check(fetch_instr, row.exp, $sformatf("fetch at %h", row.addr));
            end
            OP_HWR: host_store(row.addr, row.data);
            OP_AWR: accel_write(row.addr, rand_bits(32), 1'b0, 16'h0, 32'h0);
            OP_AWC: accel_write(row.addr, rand_bits(32), 1'b1, row.addr2, row.data);
            default: begin
                base = row.addr & 16'hffc0;   // 16-word line
                @(posedge clk);
                accel_req <= '{row.addr, 32'h0, 1'b0, 1'b1};
                @(posedge clk);
                accel_req <= '0;
                @(negedge clk);
                check(accel_rd_valid, 1, "accel_rd_valid after line read");
                for (int i = 0; i < `LINE_WORDS; i++) begin
                    wa = base + 16'(4 * i);
                    check(accel_line[i], accel_data.exists(wa) ? accel_data[wa]
                          : row.exp + 32'(4 * i), $sformatf("accel line word %0d", i));
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        ready        = 1'b0;
        rd_valid     = 1'b0;
        tx_done      = 1'b0;
        host_rd_data = '0;
        core_req     = '0;
        fetch_addr   = '0;
        accel_req    = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        ready <= 1'b1;
        serve_boot();
        for (int r = 0; r < NROWS && timeouts == 0; r++) begin
            apply_row(ROWS[r]);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- test/cpu_mem_asserts.sv
module cpu_mem_asserts
    import cpu_mem_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input seq_state_t state,
    input host_op_t   host_op,
    input logic       dm_boot_en,
    input logic       core_wr,
    input logic       accel_rd,
    input logic       accel_rd_valid,
    input logic       accel_wr_done
);

    host_wr_only: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == WRITE) |-> (state == HOST_WR))
        else $error("host WRITE driven outside HOST_WR");

    no_boot_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        !(dm_boot_en && (state == RUN)))
        else $error("data memory boot write while in RUN");

    // line read answers exactly one cycle later
    rd_valid_lag: assert property (@(posedge clk) disable iff (!rst_n)
        accel_rd_valid == $past(accel_rd))
        else $error("accel_rd_valid does not follow accel rd by one cycle");

    wr_done_slot: assert property (@(posedge clk) disable iff (!rst_n)
        accel_wr_done |-> !$past(dm_boot_en || core_wr))
        else $error("accel_wr_done after a cycle with a boot or core write");

endmodule

// sequencer side, memory-only inputs tied off
bind boot_host_seq cpu_mem_asserts seq_chk (
    .clk(clk), .rst_n(rst_n), .state(state), .host_op(host_op),
    .dm_boot_en(dm_boot.en), .core_wr(core_req.wr),
    .accel_rd(1'b0), .accel_rd_valid(1'b0), .accel_wr_done(1'b0)
);

// memory side, no state here so the sequencer checks stay vacuous
bind data_mem cpu_mem_asserts dm_chk (
    .clk(clk), .rst_n(rst_n), .state(HOST_WR), .host_op(IDLE),
    .dm_boot_en(boot.en), .core_wr(core_req.wr),
    .accel_rd(accel_req.rd), .accel_rd_valid(accel_rd_valid),
    .accel_wr_done(accel_wr_done)
);

//--- verilog/cpu_mem_top.sv
`include "cpu_mem_defs.svh"

module cpu_mem_top
    import cpu_mem_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    // host
    input  logic                                ready,
    input  logic                                rd_valid,
    input  logic                                tx_done,
    input  logic [`WORD_W-1:0]                  host_rd_data,
    output host_op_t                            host_op,
    output logic [`HOST_ADDR_W-1:0]             host_addr,
    output logic [`WORD_W-1:0]                  host_wr_data,
    // core
    input  core_req_t                           core_req,
    input  logic [`ADDR_W-1:0]                  fetch_addr,
    output logic [`WORD_W-1:0]                  core_rdata,
    output logic [`WORD_W-1:0]                  fetch_instr,
    output logic                                stall,
    // accelerator
    input  accel_req_t                          accel_req,
    output logic                                accel_wr_done,
    output logic                                accel_rd_valid,
    output logic [`LINE_WORDS-1:0][`WORD_W-1:0] accel_line
);

    mem_wr_t dm_boot;
    mem_wr_t im_boot;

    boot_host_seq seq (
        .clk(clk), .rst_n(rst_n),
        .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .host_rd_data(host_rd_data), .core_req(core_req),
        .host_op(host_op), .host_addr(host_addr), .host_wr_data(host_wr_data),
        .dm_boot(dm_boot), .im_boot(im_boot), .stall(stall)
    );

    data_mem dm (
        .clk(clk), .rst_n(rst_n),
        .boot(dm_boot), .core_req(core_req), .accel_req(accel_req),
        .core_rdata(core_rdata),
        .accel_wr_done(accel_wr_done), .accel_rd_valid(accel_rd_valid),
        .accel_line(accel_line)
    );

    instr_mem im (
        .clk(clk), .rst_n(rst_n),
        .boot(im_boot), .fetch_addr(fetch_addr),
        .fetch_instr(fetch_instr)
    );

endmodule

//--- verilog/instr_mem.sv
`include "cpu_mem_defs.svh"

module instr_mem
    import cpu_mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  mem_wr_t            boot,
    input  logic [`ADDR_W-1:0] fetch_addr,
    output logic [`WORD_W-1:0] fetch_instr
);

    localparam int IDX_W = $clog2(`IM_WORDS);

    logic [`WORD_W-1:0] mem [`IM_WORDS];

    // loaded only during boot
    always_ff @(posedge clk) begin
        if (boot.en && (boot.addr[`ADDR_W-1:IDX_W+2] == '0)) begin
            mem[boot.addr[IDX_W+1:2]] <= boot.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_instr <= '0;
        end else begin
            fetch_instr <= mem[fetch_addr[IDX_W+1:2]];   // word address
        end
    end

endmodule

//--- verilog/data_mem.sv
`include "cpu_mem_defs.svh"

module data_mem
    import cpu_mem_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  mem_wr_t                             boot,
    input  core_req_t                           core_req,
    input  accel_req_t                          accel_req,
    output logic [`WORD_W-1:0]                  core_rdata,
    output logic                                accel_wr_done,
    output logic                                accel_rd_valid,
    output logic [`LINE_WORDS-1:0][`WORD_W-1:0] accel_line
);

    localparam int IDX_W  = $clog2(`DM_WORDS);
    localparam int LINE_B = $clog2(`LINE_WORDS);

    logic [`WORD_W-1:0]      mem [`DM_WORDS];
    logic                    wr_en;
    logic [`ADDR_W-1:0]      wr_addr;
    logic [`WORD_W-1:0]      wr_data;
    logic                    accel_take;
    logic [IDX_W-LINE_B-1:0] line_idx;

    // accel only gets a free slot, and not twice for one request
    assign accel_take = accel_req.wr && !boot.en && !core_req.wr && !accel_wr_done;
    assign line_idx   = accel_req.addr[IDX_W+1:LINE_B+2];

    ////////////////////////////////////////////////////////////
    // write port, boot > core > accel
    ////////////////////////////////////////////////////////////

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = boot.addr;
        wr_data = boot.data;
        if (boot.en) begin
            wr_en = 1'b1;
        end else if (core_req.wr) begin
            wr_en   = 1'b1;
            wr_addr = core_req.addr;
            wr_data = core_req.wdata;
        end else if (accel_take) begin
            wr_en   = 1'b1;
            wr_addr = accel_req.addr;
            wr_data = accel_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr[`ADDR_W-1:IDX_W+2] == '0)) begin   // drop out of range
            mem[wr_addr[IDX_W+1:2]] <= wr_data;
        end
        if (core_req.rd) begin
            core_rdata <= mem[core_req.addr[IDX_W+1:2]];
        end
        if (accel_req.rd) begin
            for (int i = 0; i < `LINE_WORDS; i++) begin
                accel_line[i] <= mem[{line_idx, LINE_B'(i)}];   // word 0 lowest
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wr_done  <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wr_done  <= accel_take;
            accel_rd_valid <= accel_req.rd;
        end
    end

endmodule

//--- verilog/boot_host_seq.sv
`include "cpu_mem_defs.svh"

module boot_host_seq
    import cpu_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ready,
    input  logic                    rd_valid,
    input  logic                    tx_done,
    input  logic [`WORD_W-1:0]      host_rd_data,
    input  core_req_t               core_req,
    output host_op_t                host_op,
    output logic [`HOST_ADDR_W-1:0] host_addr,
    output logic [`WORD_W-1:0]      host_wr_data,
    output mem_wr_t                 dm_boot,
    output mem_wr_t                 im_boot,
    output logic                    stall
);

    localparam int CNT_W     = $clog2(`IM_SEGS);
    localparam int SEG_SHIFT = $clog2(`SEG_WORDS * 4);
    localparam logic [`ADDR_W-1:0] WORD_STEP = 4;

    seq_state_t         state, next_state;
    logic [CNT_W-1:0]   seg_cnt;        // segment within current phase
    logic [`ADDR_W-1:0] fill_addr;      // next boot write address
    logic [`ADDR_W-1:0] trap_addr;
    logic [`WORD_W-1:0] trap_data;
    logic [`ADDR_W-1:0] seg_base;
    logic [`ADDR_W-1:0] im_base;
    logic               is_im;
    logic               wait_st;
    logic               fill_st;
    logic               seg_last;
    logic               trap_hit;
    mem_wr_t            boot_wr;

    assign wait_st  = (state == DM_WAIT) || (state == IM_WAIT);
    assign fill_st  = (state == DM_FILL) || (state == IM_FILL);
    assign is_im    = (state == IM_WAIT) || (state == IM_FILL);
    assign im_base  = {{(`ADDR_W-CNT_W){1'b0}}, seg_cnt} << SEG_SHIFT;
    assign seg_base = is_im ? im_base : dm_seg_base(seg_cnt);
    assign seg_last = is_im ? (seg_cnt == CNT_W'(`IM_SEGS - 1))
                            : (seg_cnt == CNT_W'(`DM_SEGS - 1));

    // core store into the host window
    assign trap_hit = (state == RUN) && core_req.wr && (core_req.addr >= `HOST_BASE);

    ////////////////////////////////////////////////////////////
    // state transitions
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: if (ready)    next_state = DM_WAIT;
            DM_WAIT:  if (rd_valid) next_state = DM_FILL;
            DM_FILL:  if (tx_done)  next_state = seg_last ? IM_WAIT : DM_WAIT;
            IM_WAIT:  if (rd_valid) next_state = IM_FILL;
            IM_FILL:  if (tx_done)  next_state = seg_last ? RUN : IM_WAIT;
            RUN:      if (trap_hit) next_state = HOST_WR;
            HOST_WR:  if (tx_done)  next_state = RUN;
            default:  next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            seg_cnt   <= '0;
            fill_addr <= '0;
        end else begin
            state <= next_state;
            if (fill_st && tx_done) begin
                seg_cnt <= seg_last ? '0 : seg_cnt + 1'b1;   // wrap at phase change
            end
            if (wait_st && rd_valid) begin
                fill_addr <= seg_base + WORD_STEP;   // word 0 already written
            end else if (fill_st) begin
                fill_addr <= fill_addr + WORD_STEP;
            end
        end
    end

    // trapped store, held for the host write
    always_ff @(posedge clk) begin
        if (trap_hit) begin
            trap_addr <= core_req.addr;
            trap_data <= core_req.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // host side and stall
    ////////////////////////////////////////////////////////////

    always_comb begin
        host_op      = IDLE;
        host_addr    = '0;
        host_wr_data = '0;
        stall        = 1'b1;    // held through boot
        case (state)
            DM_WAIT, DM_FILL, IM_WAIT, IM_FILL: begin
                host_op                = READ;
                host_addr              = {{(`HOST_ADDR_W-`ADDR_W){1'b0}}, seg_base};
                host_addr[`IM_HOST_BIT] = is_im;
            end
            RUN: begin
                stall = trap_hit;
            end
            HOST_WR: begin
                host_op      = WRITE;
                host_addr    = {{(`HOST_ADDR_W-`ADDR_W){1'b0}}, trap_addr};
                host_wr_data = trap_data;
                stall        = !tx_done;    // core resumes with tx_done
            end
            default: begin
                host_op = IDLE;
            end
        endcase
    end

    // one boot write path, steered by phase
    always_comb begin
        boot_wr.addr = wait_st ? seg_base : fill_addr;
        boot_wr.data = host_rd_data;
        boot_wr.en   = (wait_st && rd_valid) || fill_st;
        dm_boot      = boot_wr;
        dm_boot.en   = boot_wr.en && !is_im;
        im_boot      = boot_wr;
        im_boot.en   = boot_wr.en && is_im;
    end

endmodule

//--- verilog/cpu_mem_pkg.sv
`include "cpu_mem_defs.svh"

package cpu_mem_pkg;

    // host transfer codes
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        DM_WAIT,
        DM_FILL,
        IM_WAIT,
        IM_FILL,
        RUN,
        HOST_WR
    } seq_state_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] wdata;
        logic               wr;
        logic               rd;
    } core_req_t;

    // boot write into one of the memories
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] data;
        logic               en;
    } mem_wr_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] wdata;
        logic               wr;
        logic               rd;
    } accel_req_t;

    // 0x1000 + 0x1000*n[3:2] + 0x100*n[1] + 0x40*n[0], last entry is 0x0100
    function automatic logic [`ADDR_W-1:0] dm_seg_base(input logic [$clog2(`IM_SEGS)-1:0] n);
        if (n >= `DM_SEGS - 1) begin
            return 16'h0100;
        end
        return 16'h1000 + {2'b00, n[3:2], 12'h000} + {7'b0, n[1], 8'h00} + {9'b0, n[0], 6'h00};
    endfunction

endpackage

//--- verilog/cpu_mem_defs.svh
`ifndef CPU_MEM_DEFS_SVH
`define CPU_MEM_DEFS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

`define ADDR_W       16         // core byte address
`define WORD_W       32
`define HOST_ADDR_W  64

////////////////////////////////////////////////////////////
// boot segments and host window
////////////////////////////////////////////////////////////

`define SEG_WORDS    16         // one segment is 0x40 bytes
`define DM_SEGS      17
`define IM_SEGS      48
`define IM_HOST_BIT  16         // marks an instruction segment on the host side
`define HOST_BASE    16'h9000   // stores at or above go to the host

// memory depths in words
`define DM_WORDS     8192       // bytes 0x0000 to 0x7fff
`define IM_WORDS     1024
`define LINE_WORDS   16         // 512-bit accelerator line

`endif
